//--- src/pipeline_pkg.sv
package pipeline_pkg;

  parameter int DATA_WIDTH        = 32;
  parameter int ADDR_WIDTH        = 32;
  parameter int REG_IDX_WIDTH     = 5;
  parameter int MEM_WORDS_DEFAULT = 256; // data memory depth in words

  typedef logic [DATA_WIDTH-1:0]    data_t;
  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t; // x0 is hardwired to zero

  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_control_t;

  typedef enum logic {
    ALU_SRC_B_RD2     = 1'b0,
    ALU_SRC_B_IMM_EXT = 1'b1
  } alu_src_b_t;

  typedef enum logic [1:0] {
    RESULT_SRC_ALU       = 2'd0,
    RESULT_SRC_MEM       = 2'd1, // marks a load
    RESULT_SRC_PC_PLUS_4 = 2'd2
  } result_src_t;

  // shared by both operands
  typedef enum logic [1:0] {
    FORWARD_EXECUTE_RD        = 2'd0,
    FORWARD_WRITE_BACK_RESULT = 2'd1,
    FORWARD_MEMORY_ALU_RESULT = 2'd2
  } forward_t;

endpackage

//--- src/alu.sv
`timescale 1ns/10ps

module alu
  ( input  pipeline_pkg::data_t        a
  , input  pipeline_pkg::data_t        b
  , input  pipeline_pkg::alu_control_t alu_control
  , output pipeline_pkg::data_t        out
  , output logic                       zero
  );

  logic [4:0] shamt;

  assign shamt = b[4:0]; // shifts only look at the low five bits

  always_comb begin
    case (alu_control)
      pipeline_pkg::ALU_ADD:  out = a + b;
      pipeline_pkg::ALU_SUB:  out = a - b;
      pipeline_pkg::ALU_AND:  out = a & b;
      pipeline_pkg::ALU_OR:   out = a | b;
      pipeline_pkg::ALU_XOR:  out = a ^ b;
      pipeline_pkg::ALU_SLT:  out = pipeline_pkg::data_t'($signed(a) < $signed(b));
      pipeline_pkg::ALU_SLTU: out = pipeline_pkg::data_t'(a < b);
      pipeline_pkg::ALU_SLL:  out = a << shamt;
      pipeline_pkg::ALU_SRL:  out = a >> shamt;
      pipeline_pkg::ALU_SRA:  out = pipeline_pkg::data_t'($signed(a) >>> shamt);
      default:                out = a + b;
    endcase
  end

  assign zero = (out == '0); // branch taken on equal operands via sub

endmodule

//--- src/execute.sv
`timescale 1ns/10ps

module execute
  ( input  logic                       clk
  , input  logic                       reset
  , input  pipeline_pkg::data_t        rd1
  , input  pipeline_pkg::data_t        rd2
  , input  pipeline_pkg::data_t        imm_ext
  , input  pipeline_pkg::addr_t        pc_cur
  , input  pipeline_pkg::alu_control_t alu_control
  , input  pipeline_pkg::alu_src_b_t   alu_src_b
  , input  logic                       branch
  , input  logic                       jump
  , input  pipeline_pkg::forward_t     forward_a
  , input  pipeline_pkg::forward_t     forward_b
  , input  pipeline_pkg::data_t        wb_result
  , input  pipeline_pkg::data_t        mem_alu_result
  , output pipeline_pkg::data_t        alu_result
  , output pipeline_pkg::data_t        store_data
  , output logic                       redirect
  , output pipeline_pkg::addr_t        redirect_pc
  );

  pipeline_pkg::data_t alu_input_a;
  pipeline_pkg::data_t alu_input_b;
  logic                zero_flag;

  always_comb begin
    case (forward_a)
      pipeline_pkg::FORWARD_WRITE_BACK_RESULT: alu_input_a = wb_result;
      pipeline_pkg::FORWARD_MEMORY_ALU_RESULT: alu_input_a = mem_alu_result;
      default:                                 alu_input_a = rd1;
    endcase
  end

  // forwarded rs2 feeds the store path whatever operand b turns out to be
  always_comb begin
    case (forward_b)
      pipeline_pkg::FORWARD_WRITE_BACK_RESULT: store_data = wb_result;
      pipeline_pkg::FORWARD_MEMORY_ALU_RESULT: store_data = mem_alu_result;
      default:                                 store_data = rd2;
    endcase
  end

  assign alu_input_b = (alu_src_b == pipeline_pkg::ALU_SRC_B_IMM_EXT) ? imm_ext : store_data;

  alu alu_i
    ( .a           ( alu_input_a )
    , .b           ( alu_input_b )
    , .alu_control ( alu_control )
    , .out         ( alu_result  )
    , .zero        ( zero_flag   )
    );

  assign redirect    = jump | (branch & zero_flag);
  assign redirect_pc = jump ? pipeline_pkg::addr_t'({alu_result[31:1], 1'b0}) // jalr style target
                            : pc_cur + pipeline_pkg::addr_t'(imm_ext);

  forward_codes_defined: assert property (@(posedge clk) disable iff (reset)
    forward_a inside {pipeline_pkg::FORWARD_EXECUTE_RD, pipeline_pkg::FORWARD_WRITE_BACK_RESULT,
                      pipeline_pkg::FORWARD_MEMORY_ALU_RESULT} &&
    forward_b inside {pipeline_pkg::FORWARD_EXECUTE_RD, pipeline_pkg::FORWARD_WRITE_BACK_RESULT,
                      pipeline_pkg::FORWARD_MEMORY_ALU_RESULT});

endmodule

//--- src/hazard_unit.sv
`timescale 1ns/10ps

module hazard_unit
  ( input  logic                   clk
  , input  logic                   reset
  , input  pipeline_pkg::reg_idx_t issue_rs1
  , input  pipeline_pkg::reg_idx_t issue_rs2
  , input  logic                   issue_uses_rs2
  , input  pipeline_pkg::reg_idx_t ex_rs1
  , input  pipeline_pkg::reg_idx_t ex_rs2
  , input  pipeline_pkg::reg_idx_t ex_rd
  , input  logic                   ex_is_load
  , input  pipeline_pkg::reg_idx_t mem_rd
  , input  logic                   mem_reg_write
  , input  pipeline_pkg::reg_idx_t wb_rd
  , input  logic                   wb_reg_write
  , output pipeline_pkg::forward_t forward_a
  , output pipeline_pkg::forward_t forward_b
  , output logic                   stall
  );

  logic mem_live;
  logic wb_live;

  assign mem_live = mem_reg_write && (mem_rd != '0);
  assign wb_live  = wb_reg_write && (wb_rd != '0);

  // the newer op in ex/mem beats the one in mem/wb
  assign forward_a = (mem_live && mem_rd == ex_rs1) ? pipeline_pkg::FORWARD_MEMORY_ALU_RESULT
                   : (wb_live && wb_rd == ex_rs1)   ? pipeline_pkg::FORWARD_WRITE_BACK_RESULT
                   :                                  pipeline_pkg::FORWARD_EXECUTE_RD;

  assign forward_b = (mem_live && mem_rd == ex_rs2) ? pipeline_pkg::FORWARD_MEMORY_ALU_RESULT
                   : (wb_live && wb_rd == ex_rs2)   ? pipeline_pkg::FORWARD_WRITE_BACK_RESULT
                   :                                  pipeline_pkg::FORWARD_EXECUTE_RD;

  // load data only exists from mem/wb on, so a direct consumer waits one cycle
  assign stall = ex_is_load && (ex_rd == issue_rs1 || (issue_uses_rs2 && ex_rd == issue_rs2));

  stall_one_cycle: assert property (@(posedge clk) disable iff (reset) stall |=> !stall);

endmodule

//--- src/issue_stage.sv
`timescale 1ns/10ps

module issue_stage
  ( input  logic                       clk
  , input  logic                       reset
  , input  logic                       op_valid
  , input  logic                       stall
  , input  pipeline_pkg::reg_idx_t     rs1
  , input  pipeline_pkg::reg_idx_t     rs2
  , input  pipeline_pkg::reg_idx_t     rd
  , input  pipeline_pkg::data_t        imm_ext
  , input  pipeline_pkg::addr_t        pc_cur
  , input  pipeline_pkg::alu_control_t alu_control
  , input  pipeline_pkg::alu_src_b_t   alu_src_b
  , input  pipeline_pkg::result_src_t  result_src
  , input  logic                       reg_write
  , input  logic                       mem_write
  , input  logic                       branch
  , input  logic                       jump
  , input  logic                       wb_reg_write
  , input  pipeline_pkg::reg_idx_t     wb_rd
  , input  pipeline_pkg::data_t        wb_data
  , output logic                       issue_uses_rs2
  , output pipeline_pkg::reg_idx_t     ex_rs1
  , output pipeline_pkg::reg_idx_t     ex_rs2
  , output pipeline_pkg::reg_idx_t     ex_rd
  , output pipeline_pkg::data_t        ex_rd1
  , output pipeline_pkg::data_t        ex_rd2
  , output pipeline_pkg::data_t        ex_imm_ext
  , output pipeline_pkg::addr_t        ex_pc_cur
  , output pipeline_pkg::addr_t        ex_pc_plus_4
  , output pipeline_pkg::alu_control_t ex_alu_control
  , output pipeline_pkg::alu_src_b_t   ex_alu_src_b
  , output pipeline_pkg::result_src_t  ex_result_src
  , output logic                       ex_reg_write
  , output logic                       ex_mem_write
  , output logic                       ex_branch
  , output logic                       ex_jump
  , output logic                       ex_is_load
  );

  pipeline_pkg::data_t regs [1:31]; // x0 has no storage
  pipeline_pkg::data_t rd1_read;
  pipeline_pkg::data_t rd2_read;
  logic                accept;
  logic                writes_rd;

  assign accept         = op_valid && !stall;
  assign writes_rd      = reg_write && (rd != '0); // writes to x0 are dropped here
  assign issue_uses_rs2 = (alu_src_b == pipeline_pkg::ALU_SRC_B_RD2) || mem_write;

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) regs[i] <= '0;
    end else if (wb_reg_write && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // write-first read lets the issuing op see a same-cycle write-back
  always_comb begin
    if (rs1 == '0)                          rd1_read = '0;
    else if (wb_reg_write && wb_rd == rs1)  rd1_read = wb_data;
    else                                    rd1_read = regs[rs1];
    if (rs2 == '0)                          rd2_read = '0;
    else if (wb_reg_write && wb_rd == rs2)  rd2_read = wb_data;
    else                                    rd2_read = regs[rs2];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ex_rs1       <= '0;
      ex_rs2       <= '0;
      ex_rd        <= '0;
      ex_reg_write <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_branch    <= 1'b0;
      ex_jump      <= 1'b0;
      ex_is_load   <= 1'b0;
    end else if (accept) begin
      ex_rs1       <= rs1;
      ex_rs2       <= rs2;
      ex_rd        <= rd;
      ex_reg_write <= writes_rd;
      ex_mem_write <= mem_write;
      ex_branch    <= branch;
      ex_jump      <= jump;
      ex_is_load   <= writes_rd && (result_src == pipeline_pkg::RESULT_SRC_MEM);
    end else begin // bubble
      ex_reg_write <= 1'b0;
      ex_mem_write <= 1'b0;
      ex_branch    <= 1'b0;
      ex_jump      <= 1'b0;
      ex_is_load   <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ex_rd1         <= rd1_read;
      ex_rd2         <= rd2_read;
      ex_imm_ext     <= imm_ext;
      ex_pc_cur      <= pc_cur;
      ex_pc_plus_4   <= pc_cur + pipeline_pkg::addr_t'(4);
      ex_alu_control <= alu_control;
      ex_alu_src_b   <= alu_src_b;
      ex_result_src  <= result_src;
    end
  end

endmodule

//--- src/mem_stage.sv
`timescale 1ns/10ps

module mem_stage
  #( parameter int mem_words = pipeline_pkg::MEM_WORDS_DEFAULT
  )
  ( input  logic                      clk
  , input  logic                      reset
  , input  pipeline_pkg::data_t       alu_result
  , input  pipeline_pkg::data_t       store_data
  , input  pipeline_pkg::reg_idx_t    rd
  , input  pipeline_pkg::addr_t       pc_plus_4
  , input  logic                      reg_write
  , input  logic                      mem_write
  , input  pipeline_pkg::result_src_t result_src
  , output pipeline_pkg::data_t       mem_alu_result
  , output pipeline_pkg::reg_idx_t    mem_rd
  , output logic                      mem_reg_write
  , output pipeline_pkg::reg_idx_t    wb_rd
  , output logic                      wb_reg_write
  , output pipeline_pkg::data_t       wb_result
  );

  localparam int IDX_W = $clog2(mem_words);

  pipeline_pkg::data_t       mem [mem_words];
  pipeline_pkg::data_t       m_store_data;
  pipeline_pkg::addr_t       m_pc_plus_4;
  logic                      m_mem_write;
  pipeline_pkg::result_src_t m_result_src;
  logic [IDX_W-1:0]          m_idx;
  pipeline_pkg::data_t       w_alu_result;
  pipeline_pkg::data_t       w_read_data;
  pipeline_pkg::addr_t       w_pc_plus_4;
  pipeline_pkg::result_src_t w_result_src;

  always_ff @(posedge clk) begin // ex/mem
    if (reset) begin
      mem_rd        <= '0;
      mem_reg_write <= 1'b0;
      m_mem_write   <= 1'b0;
    end else begin
      mem_rd        <= rd;
      mem_reg_write <= reg_write;
      m_mem_write   <= mem_write;
    end
    mem_alu_result <= alu_result;
    m_store_data   <= store_data;
    m_pc_plus_4    <= pc_plus_4;
    m_result_src   <= result_src;
  end

  assign m_idx = mem_alu_result[IDX_W+1:2]; // word address without the byte offset

  always_ff @(posedge clk) begin
    if (m_mem_write) mem[m_idx] <= m_store_data;
  end

  always_ff @(posedge clk) begin // mem/wb
    if (reset) begin
      wb_rd        <= '0;
      wb_reg_write <= 1'b0;
    end else begin
      wb_rd        <= mem_rd;
      wb_reg_write <= mem_reg_write;
    end
    w_alu_result <= mem_alu_result;
    w_read_data  <= mem[m_idx]; // load data registered here
    w_pc_plus_4  <= m_pc_plus_4;
    w_result_src <= m_result_src;
  end

  always_comb begin
    case (w_result_src)
      pipeline_pkg::RESULT_SRC_MEM:       wb_result = w_read_data;
      pipeline_pkg::RESULT_SRC_PC_PLUS_4: wb_result = pipeline_pkg::data_t'(w_pc_plus_4);
      default:                            wb_result = w_alu_result;
    endcase
  end

  store_in_range: assert property (@(posedge clk) disable iff (reset)
    m_mem_write |-> (mem_alu_result >> 2) < pipeline_pkg::data_t'(mem_words));

endmodule

//--- src/ex_pipeline.sv
`timescale 1ns/10ps

module ex_pipeline
  #( parameter int mem_words = pipeline_pkg::MEM_WORDS_DEFAULT
  )
  ( input  logic                       clk
  , input  logic                       reset
  , input  logic                       op_valid
  , input  pipeline_pkg::reg_idx_t     rs1
  , input  pipeline_pkg::reg_idx_t     rs2
  , input  pipeline_pkg::reg_idx_t     rd
  , input  pipeline_pkg::data_t        imm_ext
  , input  pipeline_pkg::addr_t        pc_cur
  , input  pipeline_pkg::alu_control_t alu_control
  , input  pipeline_pkg::alu_src_b_t   alu_src_b
  , input  pipeline_pkg::result_src_t  result_src
  , input  logic                       reg_write
  , input  logic                       mem_write
  , input  logic                       branch
  , input  logic                       jump
  , output logic                       stall
  , output logic                       redirect
  , output pipeline_pkg::addr_t        redirect_pc
  , output logic                       wb_valid
  , output pipeline_pkg::reg_idx_t     wb_rd
  , output pipeline_pkg::data_t        wb_data
  );

  logic                       issue_uses_rs2;
  pipeline_pkg::reg_idx_t     ex_rs1, ex_rs2, ex_rd;
  pipeline_pkg::data_t        ex_rd1, ex_rd2, ex_imm_ext;
  pipeline_pkg::addr_t        ex_pc_cur, ex_pc_plus_4;
  pipeline_pkg::alu_control_t ex_alu_control;
  pipeline_pkg::alu_src_b_t   ex_alu_src_b;
  pipeline_pkg::result_src_t  ex_result_src;
  logic                       ex_reg_write, ex_mem_write, ex_branch, ex_jump, ex_is_load;
  pipeline_pkg::forward_t     forward_a, forward_b;
  pipeline_pkg::data_t        alu_result, store_data, mem_alu_result;
  pipeline_pkg::reg_idx_t     mem_rd;
  logic                       mem_reg_write;

  issue_stage issue_stage_i
    ( .clk (clk), .reset (reset), .op_valid (op_valid), .stall (stall)
    , .rs1 (rs1), .rs2 (rs2), .rd (rd), .imm_ext (imm_ext), .pc_cur (pc_cur)
    , .alu_control (alu_control), .alu_src_b (alu_src_b), .result_src (result_src)
    , .reg_write (reg_write), .mem_write (mem_write), .branch (branch), .jump (jump)
    , .wb_reg_write (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data)
    , .issue_uses_rs2 (issue_uses_rs2)
    , .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2), .ex_rd (ex_rd)
    , .ex_rd1 (ex_rd1), .ex_rd2 (ex_rd2), .ex_imm_ext (ex_imm_ext)
    , .ex_pc_cur (ex_pc_cur), .ex_pc_plus_4 (ex_pc_plus_4)
    , .ex_alu_control (ex_alu_control), .ex_alu_src_b (ex_alu_src_b)
    , .ex_result_src (ex_result_src), .ex_reg_write (ex_reg_write)
    , .ex_mem_write (ex_mem_write), .ex_branch (ex_branch), .ex_jump (ex_jump)
    , .ex_is_load (ex_is_load)
    );

  hazard_unit hazard_unit_i
    ( .clk (clk), .reset (reset)
    , .issue_rs1 (rs1), .issue_rs2 (rs2), .issue_uses_rs2 (issue_uses_rs2)
    , .ex_rs1 (ex_rs1), .ex_rs2 (ex_rs2), .ex_rd (ex_rd), .ex_is_load (ex_is_load)
    , .mem_rd (mem_rd), .mem_reg_write (mem_reg_write)
    , .wb_rd (wb_rd), .wb_reg_write (wb_valid)
    , .forward_a (forward_a), .forward_b (forward_b), .stall (stall)
    );

  execute execute_i
    ( .clk (clk), .reset (reset)
    , .rd1 (ex_rd1), .rd2 (ex_rd2), .imm_ext (ex_imm_ext), .pc_cur (ex_pc_cur)
    , .alu_control (ex_alu_control), .alu_src_b (ex_alu_src_b)
    , .branch (ex_branch), .jump (ex_jump)
    , .forward_a (forward_a), .forward_b (forward_b)
    , .wb_result (wb_data), .mem_alu_result (mem_alu_result)
    , .alu_result (alu_result), .store_data (store_data)
    , .redirect (redirect), .redirect_pc (redirect_pc)
    );

  mem_stage #(.mem_words (mem_words)) mem_stage_i
    ( .clk (clk), .reset (reset)
    , .alu_result (alu_result), .store_data (store_data), .rd (ex_rd)
    , .pc_plus_4 (ex_pc_plus_4), .reg_write (ex_reg_write), .mem_write (ex_mem_write)
    , .result_src (ex_result_src)
    , .mem_alu_result (mem_alu_result), .mem_rd (mem_rd), .mem_reg_write (mem_reg_write)
    , .wb_rd (wb_rd), .wb_reg_write (wb_valid), .wb_result (wb_data)
    );

endmodule

//--- testbench/tb_ex_tasks.svh
`ifndef TB_EX_TASKS_SVH
`define TB_EX_TASKS_SVH

  task automatic clear_model();
    for (int i = 0; i < 32; i++) model_regs[i] = 32'd0;
    exp_redirect    = 1'b0;
    exp_redirect_pc = 32'd0;
  endtask

  function automatic pipeline_pkg::data_t expected_alu(input pipeline_pkg::alu_control_t op,
                                                       input pipeline_pkg::data_t a,
                                                       input pipeline_pkg::data_t b);
    case (op)
      pipeline_pkg::ALU_ADD:  return a + b;
      pipeline_pkg::ALU_SUB:  return a - b;
      pipeline_pkg::ALU_AND:  return a & b;
      pipeline_pkg::ALU_OR:   return a | b;
      pipeline_pkg::ALU_XOR:  return a ^ b;
      pipeline_pkg::ALU_SLT:  return {31'd0, $signed(a) < $signed(b)};
      pipeline_pkg::ALU_SLTU: return {31'd0, a < b};
      pipeline_pkg::ALU_SLL:  return a << b[4:0];
      pipeline_pkg::ALU_SRL:  return a >> b[4:0];
      pipeline_pkg::ALU_SRA:  return $signed(a) >>> b[4:0];
      default:                return 32'd0;
    endcase
  endfunction

  // update the model in issue order, then hold the op until it is accepted
  task automatic issue_op(input pipeline_pkg::reg_idx_t     op_rs1,
                          input pipeline_pkg::reg_idx_t     op_rs2,
                          input pipeline_pkg::reg_idx_t     op_rd,
                          input pipeline_pkg::data_t        op_imm,
                          input pipeline_pkg::addr_t        op_pc,
                          input pipeline_pkg::alu_control_t op_alu,
                          input pipeline_pkg::alu_src_b_t   op_src_b,
                          input pipeline_pkg::result_src_t  op_result,
                          input logic                       op_reg_write,
                          input logic                       op_mem_write,
                          input logic                       op_branch,
                          input logic                       op_jump);
    pipeline_pkg::data_t b;
    pipeline_pkg::data_t res;
    pipeline_pkg::data_t value;
    logic                held;
    b   = (op_src_b == pipeline_pkg::ALU_SRC_B_IMM_EXT) ? op_imm : model_regs[op_rs2];
    res = expected_alu(op_alu, model_regs[op_rs1], b);
    if (op_mem_write) model_mem[res[9:2]] = model_regs[op_rs2]; // word address
    case (op_result)
      pipeline_pkg::RESULT_SRC_MEM:       value = model_mem[res[9:2]];
      pipeline_pkg::RESULT_SRC_PC_PLUS_4: value = op_pc + 32'd4;
      default:                            value = res;
    endcase
    if (op_reg_write && op_rd != 5'd0) begin // x0 is never written
      model_regs[op_rd] = value;
      exp_rd_q.push_back(op_rd);
      exp_data_q.push_back(value);
    end
    exp_redirect    = op_jump || (op_branch && res == 32'd0);
    exp_redirect_pc = op_jump ? {res[31:1], 1'b0} : op_pc + op_imm;
    op_valid    = 1'b1;
    rs1         = op_rs1;
    rs2         = op_rs2;
    rd          = op_rd;
    imm_ext     = op_imm;
    pc_cur      = op_pc;
    alu_control = op_alu;
    alu_src_b   = op_src_b;
    result_src  = op_result;
    reg_write   = op_reg_write;
    mem_write   = op_mem_write;
    branch      = op_branch;
    jump        = op_jump;
    last_stalls = 0;
    held        = 1'b1;
    while (held) begin
      @(negedge clk);
      held = stall;
      if (stall) last_stalls++;
      @(posedge clk);
      #1;
    end
    op_valid = 1'b0;
  endtask

  task automatic issue_imm(input pipeline_pkg::reg_idx_t op_rd,
                           input pipeline_pkg::reg_idx_t op_rs1,
                           input pipeline_pkg::data_t    op_imm);
    issue_op(op_rs1, 5'd0, op_rd, op_imm, 32'd0, pipeline_pkg::ALU_ADD,
             pipeline_pkg::ALU_SRC_B_IMM_EXT, pipeline_pkg::RESULT_SRC_ALU,
             1'b1, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic issue_reg(input pipeline_pkg::alu_control_t op_alu,
                           input pipeline_pkg::reg_idx_t     op_rd,
                           input pipeline_pkg::reg_idx_t     op_rs1,
                           input pipeline_pkg::reg_idx_t     op_rs2);
    issue_op(op_rs1, op_rs2, op_rd, 32'd0, 32'd0, op_alu, pipeline_pkg::ALU_SRC_B_RD2,
             pipeline_pkg::RESULT_SRC_ALU, 1'b1, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic drain_writebacks();
    while (exp_rd_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    #1;
  endtask

  // the pulse shows in the cycle after acceptance and is gone one cycle later
  task automatic check_redirect();
    @(negedge clk);
    check_value("redirect", 32'(redirect), 32'(exp_redirect));
    if (exp_redirect) check_value("redirect_pc", redirect_pc, exp_redirect_pc);
    @(negedge clk);
    check_value("redirect", 32'(redirect), 32'd0);
    @(posedge clk);
    #1;
  endtask

  task automatic idle_after_reset();
    repeat (5) begin
      @(negedge clk);
      check_value("wb_valid", 32'(wb_valid), 32'd0);
      check_value("stall", 32'(stall), 32'd0);
      check_value("redirect", 32'(redirect), 32'd0);
    end
    @(posedge clk);
    #1;
    issue_imm(5'd0, 5'd0, $random(seed)); // attempted write to x0
    issue_reg(pipeline_pkg::ALU_ADD, 5'd5, 5'd0, 5'd0);
    drain_writebacks();
  endtask

  // rs1 comes from ex/mem, rs2 from mem/wb
  task automatic dependent_chain();
    pipeline_pkg::reg_idx_t prev;
    pipeline_pkg::reg_idx_t prev2;
    issue_imm(5'd1, 5'd0, $random(seed));
    issue_imm(5'd2, 5'd0, $random(seed));
    prev2 = 5'd1;
    prev  = 5'd2;
    for (int i = 0; i < 10; i++) begin
      issue_reg(pipeline_pkg::alu_control_t'(4'(i % 5)), 5'd3 + 5'(i), prev, prev2);
      prev2 = prev;
      prev  = 5'd3 + 5'(i);
    end
    drain_writebacks();
  endtask

  task automatic store_load_use();
    pipeline_pkg::data_t addr;
    addr = $random(seed) & 32'h0000_03fc; // aligned and inside the data memory
    issue_imm(5'd6, 5'd0, addr);
    issue_imm(5'd7, 5'd0, $random(seed));
    issue_op(5'd6, 5'd7, 5'd0, 32'd0, 32'd0, pipeline_pkg::ALU_ADD,
             pipeline_pkg::ALU_SRC_B_IMM_EXT, pipeline_pkg::RESULT_SRC_ALU,
             1'b0, 1'b1, 1'b0, 1'b0);
    issue_op(5'd6, 5'd0, 5'd8, 32'd0, 32'd0, pipeline_pkg::ALU_ADD,
             pipeline_pkg::ALU_SRC_B_IMM_EXT, pipeline_pkg::RESULT_SRC_MEM,
             1'b1, 1'b0, 1'b0, 1'b0);
    check_value("stall cycles of load", last_stalls, 32'd0);
    issue_reg(pipeline_pkg::ALU_ADD, 5'd9, 5'd8, 5'd7); // uses the load result at once
    check_value("stall cycles of load use", last_stalls, 32'd1);
    drain_writebacks();
  endtask

  task automatic branch_redirect();
    pipeline_pkg::data_t value;
    pipeline_pkg::addr_t pc;
    pipeline_pkg::data_t offset;
    value  = $random(seed);
    pc     = $random(seed) & 32'hffff_fffc;
    offset = ($random(seed) & 32'h0000_0ffe) - 32'h0000_0800;
    issue_imm(5'd10, 5'd0, value);
    issue_imm(5'd11, 5'd0, value);
    issue_imm(5'd12, 5'd0, value + 32'd1);
    issue_op(5'd10, 5'd11, 5'd0, offset, pc, pipeline_pkg::ALU_SUB,
             pipeline_pkg::ALU_SRC_B_RD2, pipeline_pkg::RESULT_SRC_ALU,
             1'b0, 1'b0, 1'b1, 1'b0);
    check_redirect();
    issue_op(5'd10, 5'd12, 5'd0, offset, pc + 32'd4, pipeline_pkg::ALU_SUB,
             pipeline_pkg::ALU_SRC_B_RD2, pipeline_pkg::RESULT_SRC_ALU,
             1'b0, 1'b0, 1'b1, 1'b0);
    check_redirect();
    drain_writebacks();
  endtask

  task automatic jump_link();
    pipeline_pkg::addr_t pc;
    pc = $random(seed) & 32'hffff_fffc;
    // jal takes x0 plus the immediate as its target
    issue_op(5'd0, 5'd0, 5'd13, $random(seed), pc, pipeline_pkg::ALU_ADD,
             pipeline_pkg::ALU_SRC_B_IMM_EXT, pipeline_pkg::RESULT_SRC_PC_PLUS_4,
             1'b1, 1'b0, 1'b0, 1'b1);
    check_redirect();
    issue_imm(5'd14, 5'd0, $random(seed));
    issue_op(5'd14, 5'd0, 5'd15, 32'h0000_0123, pc + 32'd8, pipeline_pkg::ALU_ADD,
             pipeline_pkg::ALU_SRC_B_IMM_EXT, pipeline_pkg::RESULT_SRC_PC_PLUS_4,
             1'b1, 1'b0, 1'b0, 1'b1); // jalr with odd offset
    check_redirect();
    drain_writebacks();
  endtask

  task automatic all_alu_ops();
    issue_imm(5'd16, 5'd0, $random(seed));
    issue_imm(5'd17, 5'd0, $random(seed));
    for (int k = 0; k < 10; k++) begin
      issue_reg(pipeline_pkg::alu_control_t'(4'(k)), 5'd18 + 5'(k), 5'd16, 5'd17);
    end
    drain_writebacks();
  endtask

`endif

//--- testbench/tb_ex_pipeline.sv
`timescale 1ns/10ps

module tb_ex_pipeline;

  localparam int total_ops      = 39; // ops issued over all tests
  localparam int timeout_cycles = 40 * total_ops;

  logic                       clk;
  logic                       reset;
  logic                       op_valid;
  pipeline_pkg::reg_idx_t     rs1;
  pipeline_pkg::reg_idx_t     rs2;
  pipeline_pkg::reg_idx_t     rd;
  pipeline_pkg::data_t        imm_ext;
  pipeline_pkg::addr_t        pc_cur;
  pipeline_pkg::alu_control_t alu_control;
  pipeline_pkg::alu_src_b_t   alu_src_b;
  pipeline_pkg::result_src_t  result_src;
  logic                       reg_write;
  logic                       mem_write;
  logic                       branch;
  logic                       jump;
  logic                       stall;
  logic                       redirect;
  pipeline_pkg::addr_t        redirect_pc;
  logic                       wb_valid;
  pipeline_pkg::reg_idx_t     wb_rd;
  pipeline_pkg::data_t        wb_data;

  integer                     seed;
  int                         cycle_count = 0;
  int                         error_count = 0;
  int                         last_stalls;       // stall cycles seen by the last issued op
  pipeline_pkg::data_t        model_regs [32];
  pipeline_pkg::data_t        model_mem [256];
  pipeline_pkg::reg_idx_t     exp_rd_q [$];      // expected write-backs in issue order
  pipeline_pkg::data_t        exp_data_q [$];
  logic                       exp_redirect;
  pipeline_pkg::addr_t        exp_redirect_pc;

  ex_pipeline #(.mem_words (pipeline_pkg::MEM_WORDS_DEFAULT)) ex_pipeline_i
    ( .clk (clk), .reset (reset), .op_valid (op_valid)
    , .rs1 (rs1), .rs2 (rs2), .rd (rd), .imm_ext (imm_ext), .pc_cur (pc_cur)
    , .alu_control (alu_control), .alu_src_b (alu_src_b), .result_src (result_src)
    , .reg_write (reg_write), .mem_write (mem_write), .branch (branch), .jump (jump)
    , .stall (stall), .redirect (redirect), .redirect_pc (redirect_pc)
    , .wb_valid (wb_valid), .wb_rd (wb_rd), .wb_data (wb_data)
    );

  always #10 clk = ~clk; // 20 ns period

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      error_count++;
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic fail_run(input string reason);
    error_count++;
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "run aborted");
  endtask

  `include "tb_ex_tasks.svh"

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      fail_run("timeout: the tests did not finish within the cycle limit");
    end
  end

  // every write-back must be the next one the model expects
  always @(negedge clk) begin
    if (!reset && wb_valid === 1'b1) begin
      if (exp_rd_q.size() == 0) begin
        fail_run($sformatf("unexpected write-back to x%0d at %0t ns", wb_rd, $time));
      end else begin
        check_value("wb_rd", 32'(wb_rd), 32'(exp_rd_q.pop_front()));
        check_value("wb_data", wb_data, exp_data_q.pop_front());
      end
    end
  end

  initial begin
    seed        = 32'hf677;
    clk         = 1'b0;
    reset       = 1'b1;
    op_valid    = 1'b0;
    rs1         = 5'd0;
    rs2         = 5'd0;
    rd          = 5'd0;
    imm_ext     = 32'd0;
    pc_cur      = 32'd0;
    alu_control = pipeline_pkg::ALU_ADD;
    alu_src_b   = pipeline_pkg::ALU_SRC_B_RD2;
    result_src  = pipeline_pkg::RESULT_SRC_ALU;
    reg_write   = 1'b0;
    mem_write   = 1'b0;
    branch      = 1'b0;
    jump        = 1'b0;
    clear_model();
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;

    idle_after_reset();
    dependent_chain();
    store_load_use();
    branch_redirect();
    jump_link();
    all_alu_ops();
    drain_writebacks();

    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- ex_pipeline.f
+incdir+testbench
src/pipeline_pkg.sv
src/alu.sv
src/execute.sv
src/hazard_unit.sv
src/issue_stage.sv
src/mem_stage.sv
src/ex_pipeline.sv
testbench/tb_ex_pipeline.sv

//--- build.sh
#!/bin/sh
# compile the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
  --top-module tb_ex_pipeline -o tb_ex_pipeline -f ex_pipeline.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_ex_pipeline > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" "$LOG"; then
  exit 0
fi
exit 1
